// File: include/lsu_macros.svh
// load/store stage sizing: data width, register index width, memory depth
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN 32

// register index width
`define LSU_REG_W 5

// data memory depth in 32-bit words
// address wraps modulo memory size
`define LSU_MEM_WORDS 256

`endif

// File: design/lsu_pkg.sv
// lsu_pkg: opcode and state encodings plus the latched request of the load/store stage
`include "lsu_macros.svh"

package lsu_pkg;

    // memory opcodes, OP_NONE passes the alu result through
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } lsu_op_e;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_RESP   = 2'd2
    } lsu_state_e;

    // request held from strobe until the result cycle
    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_XLEN-1:0]   addr;
        logic [`LSU_XLEN-1:0]   wdata;
        logic                   wen;
        logic [`LSU_REG_W-1:0]  rd;
        logic [`LSU_XLEN-1:0]   csr_wdata;
    } lsu_req_t;

endpackage

// File: design/lsu_mem_if.sv
// lsu_mem_if: data memory port shared by controller, aligner and memory
`include "lsu_macros.svh"

interface lsu_mem_if;

    // access strobe and direction, from the controller
    logic                       en;
    logic                       we;
    logic [`LSU_XLEN-1:0]       addr;
    // byte lanes and write data, from the aligner
    logic [`LSU_XLEN/8-1:0]     wmask;
    logic [`LSU_XLEN-1:0]       wdata;
    // registered read word
    logic [`LSU_XLEN-1:0]       rdata;

    modport ctrl_mp (output en, output we, output addr);

    modport align_mp (output wmask, output wdata, input rdata);

    modport mem_mp (
        input  en, input we, input addr,
        input  wmask, input wdata,
        output rdata
    );

endinterface

// File: design/lsu_ctrl.sv
// lsu_ctrl: FSM that latches a request, runs the memory access and raises the result strobe
`include "lsu_macros.svh"

module lsu_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_valid_i,
    input  lsu_pkg::lsu_op_e        op_i,
    input  logic [`LSU_XLEN-1:0]    addr_i,
    input  logic [`LSU_XLEN-1:0]    wdata_i,
    input  logic                    wen_i,
    input  logic [`LSU_REG_W-1:0]   rd_i,
    input  logic [`LSU_XLEN-1:0]    csr_wdata_i,
    input  logic                    misaligned_i,
    lsu_mem_if.ctrl_mp              mem,
    output lsu_pkg::lsu_req_t       req_o,
    output logic                    busy_o,
    output logic                    result_valid_o
);
    import lsu_pkg::*;

    lsu_state_e state_q;
    lsu_state_e state_d;
    lsu_req_t   req_q;
    logic       accept;
    logic       is_mem;
    logic       is_store;

    // only the access cycle blocks a new strobe
    assign busy_o         = (state_q == ST_ACCESS);
    assign accept         = op_valid_i && !busy_o;
    assign result_valid_o = (state_q == ST_RESP);

    assign is_mem   = (req_q.op != OP_NONE);
    assign is_store = (req_q.op inside {OP_SB, OP_SH, OP_SW});

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   state_d = accept ? ST_ACCESS : ST_IDLE;
            ST_ACCESS: state_d = ST_RESP;
            // result cycle doubles as an issue slot
            ST_RESP:   state_d = accept ? ST_ACCESS : ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request payload, held through ST_RESP
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.op        <= op_i;
            req_q.addr      <= addr_i;
            req_q.wdata     <= wdata_i;
            req_q.wen       <= wen_i;
            req_q.rd        <= rd_i;
            req_q.csr_wdata <= csr_wdata_i;
        end
    end

    // misaligned requests never reach memory
    assign mem.en   = (state_q == ST_ACCESS) && is_mem && !misaligned_i;
    assign mem.we   = mem.en && is_store;
    assign mem.addr = req_q.addr;

    assign req_o = req_q;

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
        busy_o |-> !op_valid_i)
        else $error("lsu_ctrl: strobe while busy is ignored");

    // an access always follows its strobe by one cycle
    a_en_in_access: assert property (@(posedge clk) disable iff (rst)
        mem.en |-> $past(op_valid_i && !busy_o))
        else $error("lsu_ctrl: memory enable outside ST_ACCESS");

endmodule

// File: design/lsu_align.sv
// lsu_align: store lane placement, load extraction and extension, misalignment check
`include "lsu_macros.svh"

module lsu_align (
    input  lsu_pkg::lsu_req_t       req_i,
    lsu_mem_if.align_mp             mem,
    output logic                    misaligned_o,
    output logic [`LSU_XLEN-1:0]    result_o,
    output logic                    wen_o
);
    import lsu_pkg::*;

    logic [1:0]                 byte_off;
    logic                       is_half;
    logic                       is_word;
    logic                       is_store;
    logic [7:0]                 rd_byte;
    logic [15:0]                rd_half;
    logic                       mask_ok;

    assign byte_off = req_i.addr[1:0];
    assign is_half  = (req_i.op inside {OP_LH, OP_LHU, OP_SH});
    assign is_word  = (req_i.op inside {OP_LW, OP_SW});
    assign is_store = (req_i.op inside {OP_SB, OP_SH, OP_SW});

    // halfword needs bit 0 clear, word needs both clear
    assign misaligned_o = (is_half && byte_off[0]) || (is_word && (byte_off != 2'b00));

    // store lanes and replicated data
    always_comb begin
        mem.wmask = 4'b0000;
        mem.wdata = req_i.wdata;
        case (req_i.op)
            OP_SB: begin
                mem.wmask = 4'b0001 << byte_off;
                mem.wdata = {4{req_i.wdata[7:0]}};
            end
            OP_SH: begin
                mem.wmask = byte_off[1] ? 4'b1100 : 4'b0011;
                mem.wdata = {2{req_i.wdata[15:0]}};
            end
            OP_SW: begin
                mem.wmask = 4'b1111;
            end
            default: begin
                mem.wmask = 4'b0000;
            end
        endcase
    end

    // addressed lanes of the read word
    assign rd_byte = mem.rdata[8*byte_off +: 8];
    assign rd_half = mem.rdata[16*byte_off[1] +: 16];

    always_comb begin
        case (req_i.op)
            OP_LB:   result_o = {{(`LSU_XLEN-8){rd_byte[7]}}, rd_byte};
            OP_LBU:  result_o = {{(`LSU_XLEN-8){1'b0}}, rd_byte};
            OP_LH:   result_o = {{(`LSU_XLEN-16){rd_half[15]}}, rd_half};
            OP_LHU:  result_o = {{(`LSU_XLEN-16){1'b0}}, rd_half};
            OP_LW:   result_o = mem.rdata;
            // alu result straight through
            OP_NONE: result_o = req_i.addr;
            default: result_o = '0;
        endcase
        if (misaligned_o) begin
            result_o = '0;
        end
    end

    // no register write for stores or faulting accesses
    assign wen_o = req_i.wen && !is_store && !misaligned_o;

    always_comb begin
        case (req_i.op)
            OP_SB:   mask_ok = $onehot(mem.wmask);
            OP_SH:   mask_ok = (mem.wmask inside {4'b0011, 4'b1100});
            OP_SW:   mask_ok = (mem.wmask == 4'b1111);
            default: mask_ok = (mem.wmask == 4'b0000);
        endcase
        a_mask_legal: assert final (mask_ok)
            else $error("lsu_align: illegal store mask %b", mem.wmask);
    end

endmodule

// File: design/data_sram.sv
// data_sram: byte-writable synchronous data memory with a registered read port
`include "lsu_macros.svh"

module data_sram (
    input  logic    clk,
    lsu_mem_if.mem_mp mem
);
    localparam int IDX_W   = $clog2(`LSU_MEM_WORDS);
    localparam int N_BYTES = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0]   mem_q [`LSU_MEM_WORDS];
    logic [`LSU_XLEN-1:0]   rdata_q;
    logic [IDX_W-1:0]       word_idx;

    // word index from the bits above the byte offset
    assign word_idx = mem.addr[IDX_W+1:2];

    // masked byte writes
    always_ff @(posedge clk) begin
        if (mem.en && mem.we) begin
            for (int b = 0; b < N_BYTES; b++) begin
                if (mem.wmask[b]) begin
                    mem_q[word_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
                end
            end
        end
    end

    // read word holds until the next read
    always_ff @(posedge clk) begin
        if (mem.en && !mem.we) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    assign mem.rdata = rdata_q;

    // write strobe and lane mask come from different blocks
    a_write_has_lanes: assert property (@(posedge clk)
        (mem.en && mem.we) |-> (mem.wmask != '0))
        else $error("data_sram: write with empty byte mask");

endmodule

// File: design/lsu_top.sv
// lsu_top: load/store stage with plain ports around controller, aligner and data memory
`include "lsu_macros.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_valid_i,
    input  lsu_pkg::lsu_op_e        op_i,
    input  logic [`LSU_XLEN-1:0]    addr_i,
    input  logic [`LSU_XLEN-1:0]    wdata_i,
    input  logic                    wen_i,
    input  logic [`LSU_REG_W-1:0]   rd_i,
    input  logic [`LSU_XLEN-1:0]    csr_wdata_i,
    output logic                    busy_o,
    output logic                    result_valid_o,
    output logic [`LSU_XLEN-1:0]    result_o,
    output logic                    wen_o,
    output logic [`LSU_REG_W-1:0]   rd_o,
    output logic [`LSU_XLEN-1:0]    csr_wdata_o,
    output logic                    misaligned_o
);
    import lsu_pkg::*;

    lsu_req_t   req;
    logic       misaligned;

    lsu_mem_if u_mem_if ();

    lsu_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .wen_i          (wen_i),
        .rd_i           (rd_i),
        .csr_wdata_i    (csr_wdata_i),
        .misaligned_i   (misaligned),
        .mem            (u_mem_if.ctrl_mp),
        .req_o          (req),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o)
    );

    lsu_align u_align (
        .req_i          (req),
        .mem            (u_mem_if.align_mp),
        .misaligned_o   (misaligned),
        .result_o       (result_o),
        .wen_o          (wen_o)
    );

    data_sram u_sram (
        .clk            (clk),
        .mem            (u_mem_if.mem_mp)
    );

    // write-back fields ride along with the latched request
    assign rd_o         = req.rd;
    assign csr_wdata_o  = req.csr_wdata;
    assign misaligned_o = misaligned;

endmodule

// File: tb/lsu_checker.sv
// lsu_checker: scoreboard that compares lsu_top results with queued expected values
`include "lsu_macros.svh"

module lsu_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     op_valid_i,
    input logic                     busy_i,
    input logic                     result_valid_i,
    input logic [`LSU_XLEN-1:0]     result_i,
    input logic                     wen_i,
    input logic [`LSU_REG_W-1:0]    rd_i,
    input logic [`LSU_XLEN-1:0]     csr_wdata_i,
    input logic                     misaligned_i
);
    typedef struct packed {
        int                     idx;
        logic [`LSU_XLEN-1:0]   result;
        logic                   wen;
        logic [`LSU_REG_W-1:0]  rd;
        logic [`LSU_XLEN-1:0]   csr;
        logic                   mis;
    } expect_t;

    expect_t exp_q[$];
    int      issue_q[$];
    int      cycle = 0;
    int      n_pass = 0;
    int      n_fail = 0;
    int      n_other = 0;
    bit      busy_exp = 1'b0;

    task automatic push_expected(input int idx, input logic [31:0] result, input logic wen,
                                 input logic [4:0] rd, input logic [31:0] csr, input logic mis);
        expect_t e;
        e.idx    = idx;
        e.result = result;
        e.wen    = wen;
        e.rd     = rd;
        e.csr    = csr;
        e.mis    = mis;
        exp_q.push_back(e);
    endtask

    function automatic bit field_ok(input int idx, input string name,
                                    input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch test %0d %s: got %h expected %h", idx, name, got, want);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // strobe cycle recorded on accept, latency checked on result
    always @(posedge clk) begin : watch_results
        expect_t e;
        int      issued;
        bit      ok;
        if (rst) begin
            cycle    = 0;
            busy_exp = 1'b0;
        end else begin
            // busy only in the cycle after an accepted strobe
            if (busy_i !== busy_exp) begin
                $display("mismatch busy_o at cycle %0d: got %h expected %h",
                         cycle, busy_i, busy_exp);
                n_other++;
            end
            busy_exp = op_valid_i && !busy_exp;
            if (op_valid_i && !busy_i) begin
                issue_q.push_back(cycle);
            end
            if (result_valid_i && (exp_q.size() == 0 || issue_q.size() == 0)) begin
                $display("result strobe at cycle %0d with no test waiting for it", cycle);
                n_other++;
            end else if (result_valid_i) begin
                e      = exp_q.pop_front();
                issued = issue_q.pop_front();
                ok = field_ok(e.idx, "result_o", result_i, e.result);
                ok = field_ok(e.idx, "wen_o", wen_i, e.wen) && ok;
                ok = field_ok(e.idx, "rd_o", rd_i, e.rd) && ok;
                ok = field_ok(e.idx, "csr_wdata_o", csr_wdata_i, e.csr) && ok;
                ok = field_ok(e.idx, "misaligned_o", misaligned_i, e.mis) && ok;
                if (cycle - issued != 2) begin
                    $display("test %0d result came %0d cycles after its strobe instead of 2",
                             e.idx, cycle - issued);
                    ok = 1'b0;
                end
                if (ok) begin
                    n_pass++;
                    $display("test %0d ok", e.idx);
                end else begin
                    n_fail++;
                    $display("test %0d failed", e.idx);
                end
            end
            cycle++;
        end
    end

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int failures();
        return n_fail + n_other;
    endfunction

    task automatic report();
        if (exp_q.size() != 0) begin
            $display("%0d tests never produced a result", exp_q.size());
            n_other += exp_q.size();
        end
        $display("tests passed %0d failed %0d other errors %0d", n_pass, n_fail, n_other);
    endtask

endmodule

// File: tb/tb_lsu.sv
// tb_lsu: testbench running a stimulus table through lsu_top against a byte memory model
`include "lsu_macros.svh"

module tb_lsu;
    import lsu_pkg::*;

    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_XLEN-1:0]   addr;
        logic [`LSU_XLEN-1:0]   wdata;
        logic                   wen;
        logic [`LSU_REG_W-1:0]  rd;
        logic [`LSU_XLEN-1:0]   csr;
        logic                   rnd;
    } test_t;

    logic                   clk;
    logic                   rst;
    logic                   op_valid_i;
    lsu_op_e                op_i;
    logic [`LSU_XLEN-1:0]   addr_i;
    logic [`LSU_XLEN-1:0]   wdata_i;
    logic [`LSU_XLEN-1:0]   csr_wdata_i;
    logic                   wen_i;
    logic [`LSU_REG_W-1:0]  rd_i;
    logic                   busy_o;
    logic                   result_valid_o;
    logic                   wen_o;
    logic                   misaligned_o;
    logic [`LSU_XLEN-1:0]   result_o;
    logic [`LSU_XLEN-1:0]   csr_wdata_o;
    logic [`LSU_REG_W-1:0]  rd_o;

    logic [7:0]             ref_mem [`LSU_MEM_WORDS*4];
    test_t                  tests[$];
    logic [31:0]            rng_state;

    lsu_top u_dut (.*);

    lsu_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .op_valid_i     (op_valid_i),
        .busy_i         (busy_o),
        .result_valid_i (result_valid_o),
        .result_i       (result_o),
        .wen_i          (wen_o),
        .rd_i           (rd_o),
        .csr_wdata_i    (csr_wdata_o),
        .misaligned_i   (misaligned_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic add_entry(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic wen, input logic [4:0] rd, input logic [31:0] csr,
                             input logic rnd);
        tests.push_back({op, addr, wdata, wen, rd, csr, rnd});
    endtask

    // reference memory update and expected write-back fields
    task automatic model_entry(input test_t t, output logic [31:0] res,
                               output logic wen, output logic mis);
        int unsigned a;
        logic [15:0] h;
        a   = ((t.addr >> 2) % `LSU_MEM_WORDS) * 4 + t.addr[1:0];
        mis = ((t.op inside {OP_LH, OP_LHU, OP_SH}) && t.addr[0]) ||
              ((t.op inside {OP_LW, OP_SW}) && t.addr[1:0] != 2'b00);
        h   = {ref_mem[a + 1], ref_mem[a]};
        res = 32'h0;
        if (!mis) begin
            case (t.op)
                OP_NONE: res = t.addr;
                OP_LB:   res = {{24{ref_mem[a][7]}}, ref_mem[a]};
                OP_LBU:  res = {24'h0, ref_mem[a]};
                OP_LH:   res = {{16{h[15]}}, h};
                OP_LHU:  res = {16'h0, h};
                OP_LW:   res = {ref_mem[a + 3], ref_mem[a + 2], h};
                OP_SB:   ref_mem[a] = t.wdata[7:0];
                OP_SH:   {ref_mem[a + 1], ref_mem[a]} = t.wdata[15:0];
                OP_SW:   {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]} = t.wdata;
                default: res = 32'h0;
            endcase
        end
        wen = t.wen && !(t.op inside {OP_SB, OP_SH, OP_SW}) && !mis;
    endtask

    initial begin : stimulus
        test_t       t;
        logic [31:0] exp_res;
        logic        exp_wen;
        logic        exp_mis;
        rst         = 1'b1;
        op_valid_i  = 1'b0;
        op_i        = OP_NONE;
        addr_i      = '0;
        wdata_i     = '0;
        wen_i       = 1'b0;
        rd_i        = '0;
        csr_wdata_i = '0;
        rng_state   = 32'd67986;
        add_entry(OP_SW,   32'h0000_0010, 32'h0,         1'b1, 5'd1,  32'h0000_1001, 1'b1);
        add_entry(OP_LW,   32'h0000_0010, 32'h0,         1'b1, 5'd2,  32'h0000_1002, 1'b0);
        // partial stores merged into one word
        add_entry(OP_SW,   32'h0000_0020, 32'h1122_3344, 1'b0, 5'd3,  32'h0000_1003, 1'b0);
        add_entry(OP_SB,   32'h0000_0021, 32'hffff_ffa5, 1'b1, 5'd4,  32'h0000_1004, 1'b0);
        add_entry(OP_SH,   32'h0000_0022, 32'h0,         1'b1, 5'd5,  32'h0000_1005, 1'b1);
        add_entry(OP_LW,   32'h0000_0020, 32'h0,         1'b1, 5'd6,  32'h0000_1006, 1'b0);
        // remaining byte lanes and the low halfword
        add_entry(OP_SW,   32'h0000_0024, 32'h5566_7788, 1'b1, 5'd22, 32'h0000_1016, 1'b0);
        add_entry(OP_SH,   32'h0000_0024, 32'h0000_9abc, 1'b1, 5'd23, 32'h0000_1017, 1'b0);
        add_entry(OP_SB,   32'h0000_0027, 32'h0000_00de, 1'b1, 5'd24, 32'h0000_1018, 1'b0);
        add_entry(OP_LW,   32'h0000_0024, 32'h0,         1'b1, 5'd25, 32'h0000_1019, 1'b0);
        add_entry(OP_SW,   32'h0000_0028, 32'h0102_0304, 1'b1, 5'd26, 32'h0000_101a, 1'b0);
        add_entry(OP_SB,   32'h0000_0028, 32'h0000_00e7, 1'b1, 5'd27, 32'h0000_101b, 1'b0);
        add_entry(OP_SB,   32'h0000_002a, 32'h0000_007e, 1'b1, 5'd28, 32'h0000_101c, 1'b0);
        add_entry(OP_LW,   32'h0000_0028, 32'h0,         1'b1, 5'd29, 32'h0000_101d, 1'b0);
        // lanes with top bit set and clear
        add_entry(OP_SW,   32'h0000_0030, 32'h807f_01fe, 1'b1, 5'd7,  32'h0000_1007, 1'b0);
        add_entry(OP_LB,   32'h0000_0030, 32'h0,         1'b1, 5'd8,  32'h0000_1008, 1'b0);
        add_entry(OP_LB,   32'h0000_0031, 32'h0,         1'b1, 5'd9,  32'h0000_1009, 1'b0);
        add_entry(OP_LBU,  32'h0000_0033, 32'h0,         1'b1, 5'd10, 32'h0000_100a, 1'b0);
        add_entry(OP_LH,   32'h0000_0030, 32'h0,         1'b1, 5'd11, 32'h0000_100b, 1'b0);
        add_entry(OP_LH,   32'h0000_0032, 32'h0,         1'b1, 5'd12, 32'h0000_100c, 1'b0);
        add_entry(OP_LHU,  32'h0000_0032, 32'h0,         1'b1, 5'd13, 32'h0000_100d, 1'b0);
        add_entry(OP_NONE, 32'h0,         32'h0,         1'b1, 5'd14, 32'h0000_100e, 1'b1);
        add_entry(OP_NONE, 32'hdead_beef, 32'h0,         1'b0, 5'd15, 32'h0000_100f, 1'b0);
        // faulting accesses leave the word alone
        add_entry(OP_SW,   32'h0000_0040, 32'hcafe_f00d, 1'b1, 5'd16, 32'h0000_1010, 1'b0);
        add_entry(OP_SH,   32'h0000_0041, 32'h0,         1'b1, 5'd17, 32'h0000_1011, 1'b1);
        add_entry(OP_SW,   32'h0000_0042, 32'h0,         1'b1, 5'd18, 32'h0000_1012, 1'b1);
        add_entry(OP_LH,   32'h0000_0043, 32'h0,         1'b1, 5'd19, 32'h0000_1013, 1'b0);
        add_entry(OP_LW,   32'h0000_0041, 32'h0,         1'b1, 5'd20, 32'h0000_1014, 1'b0);
        add_entry(OP_LW,   32'h0000_0040, 32'h0,         1'b1, 5'd21, 32'h0000_1015, 1'b0);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (tests[i]) begin
            t = tests[i];
            if (t.rnd) begin
                rng_state = xorshift32(rng_state);
                if (t.op == OP_NONE) begin
                    t.addr = rng_state;
                end else begin
                    t.wdata = rng_state;
                end
            end
            while (busy_o) begin
                @(posedge clk);
                #1;
            end
            model_entry(t, exp_res, exp_wen, exp_mis);
            u_checker.push_expected(i, exp_res, exp_wen, t.rd, t.csr, exp_mis);
            op_valid_i  = 1'b1;
            op_i        = t.op;
            addr_i      = t.addr;
            wdata_i     = t.wdata;
            wen_i       = t.wen;
            rd_i        = t.rd;
            csr_wdata_i = t.csr;
            @(posedge clk);
            #1;
            op_valid_i  = 1'b0;
        end
        while (u_checker.pending() != 0) @(posedge clk);
        @(posedge clk);
        u_checker.report();
        if (u_checker.failures() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // four cycles per entry covers the two-cycle issue interval with room to spare
    initial begin : watchdog
        @(negedge rst);
        repeat (tests.size() * 4 + 20) @(posedge clk);
        $display("timeout: results still outstanding after %0d cycles", tests.size() * 4 + 20);
        u_checker.report();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
design/lsu_pkg.sv
design/lsu_mem_if.sv
design/lsu_ctrl.sv
design/lsu_align.sv
design/data_sram.sv
design/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv
